/* src/pinmux_pkg.sv */
// Shared constants, register map and bus/PWM structs for the pad controller; import where used
package pinmux_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------
  localparam int NUM_PADS  = 16;
  localparam int PWM_CNT_W = 16;
  localparam int US_CNT_W  = 10;

  // Register bus widths
  localparam int ADDR_W = 8;
  localparam int DATA_W = 32;

  typedef logic [DATA_W-1:0]   word_t;
  typedef logic [NUM_PADS-1:0] pad_vec_t;

  // Bus request from the master in 46 bits
  typedef struct packed {
    logic              cs;
    logic              wr;
    logic [ADDR_W-1:0] addr;
    word_t             wdata;
    logic [3:0]        be;
  } reg_req_t;

  // Bus response with rdata only meaningful during ack
  typedef struct packed {
    word_t rdata;
    logic  ack;
  } reg_rsp_t;

  // One PWM channel config with the low count in the upper half
  typedef struct packed {
    logic [PWM_CNT_W-1:0] low;
    logic [PWM_CNT_W-1:0] high;
  } pwm_cfg_t;

  // Channel output towards the pad mux
  typedef struct packed {
    logic en;
    logic wfm;
  } pwm_drive_t;

  // ------------------------------
  // Register offsets
  // ------------------------------
  localparam logic [ADDR_W-1:0] REG_GPIO_DIR = 8'h00;
  localparam logic [ADDR_W-1:0] REG_GPIO_OUT = 8'h04;
  localparam logic [ADDR_W-1:0] REG_GPIO_IN  = 8'h08;
  localparam logic [ADDR_W-1:0] REG_PWM_ENB  = 8'h0C;
  localparam logic [ADDR_W-1:0] REG_PULSE_US = 8'h10;
  localparam logic [ADDR_W-1:0] REG_PWM_BASE = 8'h20;

  // Divider reset value for 50 clocks per microsecond
  localparam logic [US_CNT_W-1:0] PULSE_US_RST = 10'd49;

endpackage

/* src/pinmux_regs.sv */
// Register bank on the cs/ack bus; holds GPIO, PWM and divider config and samples the pads
`timescale 1ns/1ps

module pinmux_regs #(
  parameter int NUM_PWM = 6
) (
  input  logic                                  mclk_i,
  input  logic                                  rst_i,
  input  pinmux_pkg::reg_req_t                  req_i,
  output pinmux_pkg::reg_rsp_t                  rsp_o,
  input  pinmux_pkg::pad_vec_t                  io_in_i,
  output pinmux_pkg::pad_vec_t                  gpio_dir_o,
  output pinmux_pkg::pad_vec_t                  gpio_out_o,
  output logic [NUM_PWM-1:0]                    pwm_enb_o,
  output pinmux_pkg::pwm_cfg_t [NUM_PWM-1:0]    pwm_cfg_o,
  output logic [pinmux_pkg::US_CNT_W-1:0]       pulse_us_o,
  output logic                                  pulse_us_wr_o
);
  import pinmux_pkg::*;

  // Bus control
  logic     ack_q;
  logic     acc_en;
  logic     wr_en;
  logic     rd_en;
  word_t    rdata_q;
  word_t    be_mask;
  word_t    rd_word;
  word_t    wr_word;

  // Config and sampled input
  pad_vec_t               gpio_dir_q;
  pad_vec_t               gpio_out_q;
  pad_vec_t               gpio_in_q;
  logic [NUM_PWM-1:0]     pwm_enb_q;
  pwm_cfg_t [NUM_PWM-1:0] pwm_cfg_q;
  logic [US_CNT_W-1:0]    pulse_us_q;
  logic                   pulse_us_wr_q;

  // Channel k sits 4k above the PWM base
  function automatic logic [ADDR_W-1:0] pwm_addr(input int k);
    return ADDR_W'(REG_PWM_BASE + 4 * k);
  endfunction

  // ------------------------------
  // Handshake
  // ------------------------------
  // Only the first sampled cs cycle is an access
  assign acc_en = req_i.cs & ~ack_q;
  assign wr_en  = acc_en & req_i.wr;
  assign rd_en  = acc_en & ~req_i.wr;

  // Ack one edge after cs, blocked right after an ack
  always_ff @(posedge mclk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= acc_en;
    end
  end

  // Byte lane mask
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      be_mask[8*i +: 8] = {8{req_i.be[i]}};
    end
  end

  // ------------------------------
  // Read mux
  // ------------------------------
  always_comb begin
    case (req_i.addr)
      REG_GPIO_DIR: rd_word = {{(DATA_W-NUM_PADS){1'b0}}, gpio_dir_q};
      REG_GPIO_OUT: rd_word = {{(DATA_W-NUM_PADS){1'b0}}, gpio_out_q};
      REG_GPIO_IN:  rd_word = {{(DATA_W-NUM_PADS){1'b0}}, gpio_in_q};
      REG_PWM_ENB:  rd_word = {{(DATA_W-NUM_PWM){1'b0}}, pwm_enb_q};
      REG_PULSE_US: rd_word = {{(DATA_W-US_CNT_W){1'b0}}, pulse_us_q};
      default:      rd_word = '0;
    endcase
    // PWM channel window
    for (int k = 0; k < NUM_PWM; k++) begin
      if (req_i.addr == pwm_addr(k)) begin
        rd_word = pwm_cfg_q[k];
      end
    end
  end

  // Merge of current contents and new bytes
  assign wr_word = (rd_word & ~be_mask) | (req_i.wdata & be_mask);

  // Read data, held while ack is up
  always_ff @(posedge mclk_i) begin
    if (rd_en) begin
      rdata_q <= rd_word;
    end
  end

  // ------------------------------
  // Config writes
  // ------------------------------
  always_ff @(posedge mclk_i) begin
    if (rst_i) begin
      gpio_dir_q    <= '0;
      gpio_out_q    <= '0;
      pwm_enb_q     <= '0;
      pwm_cfg_q     <= '0;
      pulse_us_q    <= PULSE_US_RST;
      pulse_us_wr_q <= 1'b0;
    end else begin
      pulse_us_wr_q <= 1'b0;
      if (wr_en) begin
        case (req_i.addr)
          REG_GPIO_DIR: gpio_dir_q <= wr_word[NUM_PADS-1:0];
          REG_GPIO_OUT: gpio_out_q <= wr_word[NUM_PADS-1:0];
          REG_PWM_ENB:  pwm_enb_q  <= wr_word[NUM_PWM-1:0];
          REG_PULSE_US: begin
            pulse_us_q    <= wr_word[US_CNT_W-1:0];
            // Restart strobe for the timebase
            pulse_us_wr_q <= 1'b1;
          end
          default: begin
          end
        endcase
        for (int k = 0; k < NUM_PWM; k++) begin
          if (req_i.addr == pwm_addr(k)) begin
            pwm_cfg_q[k] <= wr_word;
          end
        end
      end
    end
  end

  // Pad input capture every cycle
  always_ff @(posedge mclk_i) begin
    gpio_in_q <= io_in_i;
  end

  assign rsp_o         = '{rdata: rdata_q, ack: ack_q};
  assign gpio_dir_o    = gpio_dir_q;
  assign gpio_out_o    = gpio_out_q;
  assign pwm_enb_o     = pwm_enb_q;
  assign pwm_cfg_o     = pwm_cfg_q;
  assign pulse_us_o    = pulse_us_q;
  assign pulse_us_wr_o = pulse_us_wr_q;

endmodule

/* src/pinmux_timebase.sv */
// Microsecond and millisecond tick generator; divider from the register bank, restart on rewrite
`timescale 1ns/1ps

module pinmux_timebase #(
  parameter int TICKS_PER_MS = 1000
) (
  input  logic                            mclk_i,
  input  logic                            rst_i,
  input  logic [pinmux_pkg::US_CNT_W-1:0] pulse_us_i,
  input  logic                            restart_i,
  output logic                            tick_us_o,
  output logic                            tick_ms_o
);
  import pinmux_pkg::*;

  // Guard against a zero width counter
  localparam int MS_CNT_W = (TICKS_PER_MS > 1) ? $clog2(TICKS_PER_MS) : 1;

  logic [US_CNT_W-1:0] us_cnt_q;
  logic [MS_CNT_W-1:0] ms_cnt_q;
  logic                tick_us_q;
  logic                tick_ms_q;

  // Microsecond stage, period of divider+1 clocks
  always_ff @(posedge mclk_i) begin
    if (rst_i || restart_i) begin
      us_cnt_q  <= '0;
      tick_us_q <= 1'b0;
    end else if (us_cnt_q >= pulse_us_i) begin
      // >= also covers a divider lowered mid count
      us_cnt_q  <= '0;
      tick_us_q <= 1'b1;
    end else begin
      us_cnt_q  <= us_cnt_q + 1'b1;
      tick_us_q <= 1'b0;
    end
  end

  // Millisecond stage counts microsecond ticks
  always_ff @(posedge mclk_i) begin
    if (rst_i || restart_i) begin
      ms_cnt_q  <= '0;
      tick_ms_q <= 1'b0;
    end else begin
      tick_ms_q <= 1'b0;
      if (tick_us_q) begin
        if (ms_cnt_q == MS_CNT_W'(TICKS_PER_MS - 1)) begin
          ms_cnt_q  <= '0;
          tick_ms_q <= 1'b1;
        end else begin
          ms_cnt_q <= ms_cnt_q + 1'b1;
        end
      end
    end
  end

  assign tick_us_o = tick_us_q;
  assign tick_ms_o = tick_ms_q;

endmodule

/* src/pwm_channel.sv */
// One PWM waveform generator stepping on millisecond ticks; instantiated once per channel
`timescale 1ns/1ps

module pwm_channel (
  input  logic                   mclk_i,
  input  logic                   rst_i,
  input  logic                   tick_ms_i,
  input  logic                   enb_i,
  input  pinmux_pkg::pwm_cfg_t   cfg_i,
  output pinmux_pkg::pwm_drive_t drive_o
);
  import pinmux_pkg::*;

  logic                 en_q;
  logic                 run_q;
  logic                 phase_q;
  logic [PWM_CNT_W-1:0] cnt_q;
  logic [PWM_CNT_W-1:0] len;
  logic [PWM_CNT_W-1:0] last_cnt;

  // Length of the current phase in ticks
  assign len = phase_q ? cfg_i.high : cfg_i.low;
  // Zero length behaves as one tick
  assign last_cnt = (len == '0) ? '0 : len - 1'b1;

  always_ff @(posedge mclk_i) begin
    if (rst_i || !enb_i) begin
      en_q    <= 1'b0;
      run_q   <= 1'b0;
      phase_q <= 1'b0;
      cnt_q   <= '0;
    end else begin
      en_q <= 1'b1;
      if (tick_ms_i) begin
        if (!run_q) begin
          // First tick after enable starts the high phase
          run_q   <= 1'b1;
          phase_q <= 1'b1;
          cnt_q   <= '0;
        end else if (cnt_q >= last_cnt) begin
          phase_q <= ~phase_q;
          cnt_q   <= '0;
        end else begin
          cnt_q <= cnt_q + 1'b1;
        end
      end
    end
  end

  // Pad is claimed as soon as en is set, low until first tick
  assign drive_o = '{en: en_q, wfm: phase_q};

endmodule

/* src/pad_mux.sv */
// Per-pad output select; PWM channel n overrides GPIO on pad n, oen is active low
`timescale 1ns/1ps

module pad_mux #(
  parameter int NUM_PWM = 6
) (
  input  pinmux_pkg::pwm_drive_t [NUM_PWM-1:0] pwm_i,
  input  pinmux_pkg::pad_vec_t                 gpio_dir_i,
  input  pinmux_pkg::pad_vec_t                 gpio_out_i,
  output pinmux_pkg::pad_vec_t                 io_out_o,
  output pinmux_pkg::pad_vec_t                 io_oen_o
);
  import pinmux_pkg::*;

  always_comb begin
    // Undriven pads float, out held low
    io_out_o = '0;
    io_oen_o = '1;

    // ------------------------------
    // GPIO outputs
    // ------------------------------
    for (int n = 0; n < NUM_PADS; n++) begin
      if (gpio_dir_i[n]) begin
        io_out_o[n] = gpio_out_i[n];
        io_oen_o[n] = 1'b0;
      end
    end

    // ------------------------------
    // PWM override
    // ------------------------------
    // Pad n carries channel n, direction bit ignored
    for (int n = 0; n < NUM_PWM; n++) begin
      if (pwm_i[n].en) begin
        io_out_o[n] = pwm_i[n].wfm;
        io_oen_o[n] = 1'b0;
      end
    end
  end

endmodule

/* src/pinmux_top.sv */
// Pad controller top; register bank, timebase, PWM channels and pad mux wired together
`timescale 1ns/1ps

module pinmux_top #(
  parameter int NUM_PWM      = 6,
  parameter int TICKS_PER_MS = 1000
) (
  input  logic                 mclk_i,
  input  logic                 rst_i,
  input  pinmux_pkg::reg_req_t req_i,
  output pinmux_pkg::reg_rsp_t rsp_o,
  input  pinmux_pkg::pad_vec_t io_in_i,
  output pinmux_pkg::pad_vec_t io_out_o,
  output pinmux_pkg::pad_vec_t io_oen_o,
  output logic                 pulse_1ms_o
);
  import pinmux_pkg::*;

  // Register bank outputs
  pad_vec_t               gpio_dir;
  pad_vec_t               gpio_out;
  logic [NUM_PWM-1:0]     pwm_enb;
  pwm_cfg_t [NUM_PWM-1:0] pwm_cfg;
  logic [US_CNT_W-1:0]    pulse_us;
  logic                   pulse_us_wr;

  // Channel outputs towards the pads
  pwm_drive_t [NUM_PWM-1:0] pwm_drive;

  pinmux_regs #(
    .NUM_PWM (NUM_PWM)
  ) u_regs (
    .mclk_i        (mclk_i),
    .rst_i         (rst_i),
    .req_i         (req_i),
    .rsp_o         (rsp_o),
    .io_in_i       (io_in_i),
    .gpio_dir_o    (gpio_dir),
    .gpio_out_o    (gpio_out),
    .pwm_enb_o     (pwm_enb),
    .pwm_cfg_o     (pwm_cfg),
    .pulse_us_o    (pulse_us),
    .pulse_us_wr_o (pulse_us_wr)
  );

  // Millisecond tick also leaves the block
  pinmux_timebase #(
    .TICKS_PER_MS (TICKS_PER_MS)
  ) u_timebase (
    .mclk_i     (mclk_i),
    .rst_i      (rst_i),
    .pulse_us_i (pulse_us),
    .restart_i  (pulse_us_wr),
    .tick_us_o  (),
    .tick_ms_o  (pulse_1ms_o)
  );

  // ------------------------------
  // PWM channels
  // ------------------------------
  for (genvar k = 0; k < NUM_PWM; k++) begin : g_pwm
    pwm_channel u_pwm (
      .mclk_i    (mclk_i),
      .rst_i     (rst_i),
      .tick_ms_i (pulse_1ms_o),
      .enb_i     (pwm_enb[k]),
      .cfg_i     (pwm_cfg[k]),
      .drive_o   (pwm_drive[k])
    );
  end

  pad_mux #(
    .NUM_PWM (NUM_PWM)
  ) u_pad_mux (
    .pwm_i      (pwm_drive),
    .gpio_dir_i (gpio_dir),
    .gpio_out_i (gpio_out),
    .io_out_o   (io_out_o),
    .io_oen_o   (io_oen_o)
  );

endmodule

/* include/pinmux_tb_tasks.svh */
// Bus, compare and wait tasks for the pinmux testbench; include inside tb_pinmux after its signals
`ifndef PINMUX_TB_TASKS_SVH
`define PINMUX_TB_TASKS_SVH

// Expects mclk, req, rsp, io_out, pulse_1ms, err_cnt and ack_cnt in the including module
localparam int BUS_TIMEOUT = 20;

// One clock with stimulus 1 ns past the edge
task automatic step();
  @(posedge mclk);
  #1;
endtask

task automatic wait_cycles(input int n);
  for (int i = 0; i < n; i++) begin
    step();
  end
endtask

// ------------------------------
// Compare helpers
// ------------------------------
task automatic check_word(input string name, input word_t got, input word_t exp);
  if (got !== exp) begin
    $display("Mismatch %s got %h exp %h", name, got, exp);
    err_cnt++;
  end
endtask

task automatic check_pads(input string name, input pad_vec_t got, input pad_vec_t exp);
  if (got !== exp) begin
    $display("Mismatch %s got %h exp %h", name, got, exp);
    err_cnt++;
  end
endtask

task automatic check_cycles(input string name, input int got, input int exp);
  if (got != exp) begin
    $display("Mismatch %s got %0h exp %0h", name, got, exp);
    err_cnt++;
  end
endtask

// ------------------------------
// Bus access
// ------------------------------
// Single request that returns the rdata seen with ack
task automatic bus_xfer(input logic wr, input logic [ADDR_W-1:0] addr,
                        input word_t wdata, input logic [3:0] be, output word_t rdata);
  int n;
  req = '{cs: 1'b1, wr: wr, addr: addr, wdata: wdata, be: be};
  n = 0;
  rdata = '0;
  do begin
    step();
    n++;
  end while (!rsp.ack && n < BUS_TIMEOUT);
  if (!rsp.ack) begin
    $display("No ack within %0d cycles for addr %h", BUS_TIMEOUT, addr);
    err_cnt++;
  end else begin
    ack_cnt++;
    rdata = rsp.rdata;
  end
  req.cs = 1'b0;
  // Ack must not repeat
  step();
  if (rsp.ack) begin
    $display("Ack repeated in the cycle after the ack for addr %h", addr);
    err_cnt++;
  end
endtask

task automatic bus_write(input logic [ADDR_W-1:0] addr, input word_t data,
                         input logic [3:0] be = 4'hF);
  word_t unused;
  bus_xfer(1'b1, addr, data, be, unused);
endtask

task automatic bus_read(input logic [ADDR_W-1:0] addr, output word_t data);
  bus_xfer(1'b0, addr, '0, 4'hF, data);
endtask

// ------------------------------
// Waits
// ------------------------------
// Cycles up to the next millisecond tick or -1 on timeout
task automatic wait_ms_tick(input int limit, output int cyc);
  cyc = 0;
  do begin
    step();
    cyc++;
  end while (!pulse_1ms && cyc < limit);
  if (!pulse_1ms) begin
    cyc = -1;
  end
endtask

// Length of the current run at one level on a pad
task automatic measure_run(input int pad, input logic level, input int limit, output int len);
  len = 0;
  while (io_out[pad] === level && len < limit) begin
    step();
    len++;
  end
endtask

`endif

/* verif/tb_pinmux.sv */
// Directed testbench for the pad controller; compile with the file list, top module tb_pinmux
`timescale 1ns/1ps

module tb_pinmux;
  import pinmux_pkg::*;

  // ------------------------------
  // Test constants
  // ------------------------------
  localparam int NUM_PWM      = 6;
  localparam int TICKS_PER_MS = 10;
  localparam int SEED         = 73371;
  // Divider used from the timebase test on
  localparam int DIV_TEST     = 4;
  localparam int MS_PERIOD    = (DIV_TEST + 1) * TICKS_PER_MS;
  // Upper bound for any tick or run wait
  localparam int RUN_LIMIT    = 600;

  logic     mclk;
  logic     rst;
  reg_req_t req;
  reg_rsp_t rsp;
  pad_vec_t io_in;
  pad_vec_t io_out;
  pad_vec_t io_oen;
  logic     pulse_1ms;

  // Scoreboard counters
  int err_cnt;
  int ack_cnt;
  int ack_seen;
  int test_cnt;
  int fail_cnt;
  // Channel picked for the PWM and release tests
  int pwm_ch;

  `include "pinmux_tb_tasks.svh"

  pinmux_top #(
    .NUM_PWM      (NUM_PWM),
    .TICKS_PER_MS (TICKS_PER_MS)
  ) i_dut (
    .mclk_i      (mclk),
    .rst_i       (rst),
    .req_i       (req),
    .rsp_o       (rsp),
    .io_in_i     (io_in),
    .io_out_o    (io_out),
    .io_oen_o    (io_oen),
    .pulse_1ms_o (pulse_1ms)
  );

  initial mclk = 1'b0;
  always #5 mclk = ~mclk;

  // Independent count of ack pulses on the bus
  always @(posedge mclk) begin
    if (rsp.ack === 1'b1) begin
      ack_seen++;
    end
  end

  task automatic finish_test(input string name, input int start_err);
    test_cnt++;
    if (err_cnt == start_err) begin
      $display("Test %s passed", name);
    end else begin
      fail_cnt++;
      $display("Test %s failed with %0d errors", name, err_cnt - start_err);
    end
  endtask

  // Measured run length on one pad against its expected cycle count
  task automatic timed_run(input int pad, input logic level, input int exp, input string name);
    int len;
    measure_run(pad, level, RUN_LIMIT, len);
    if (len >= RUN_LIMIT) begin
      $display("Pad %0d stuck at %b for %0d cycles", pad, level, len);
      err_cnt++;
    end else begin
      check_cycles(name, len, exp);
    end
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic test_reset_defaults();
    int    start;
    word_t rd;
    start = err_cnt;
    for (int i = 0; i < 4; i++) begin
      check_word("rsp.ack", word_t'(rsp.ack), '0);
      step();
    end
    check_pads("io_oen_o", io_oen, '1);
    check_pads("io_out_o", io_out, '0);
    check_word("pulse_1ms_o", word_t'(pulse_1ms), '0);
    bus_read(REG_PULSE_US, rd);
    check_word("REG_PULSE_US", rd, 32'd49);
    finish_test("reset_defaults", start);
  endtask

  task automatic test_reg_access();
    int                start;
    int                acks0;
    int                seen0;
    int                n_req;
    word_t             wd;
    word_t             rd;
    word_t             keep;
    logic [ADDR_W-1:0] addr;
    start = err_cnt;
    acks0 = ack_cnt;
    seen0 = ack_seen;
    n_req = 0;
    // Only implemented bits read back
    for (int i = 0; i < 4; i++) begin
      wd = word_t'($urandom);
      bus_write(REG_GPIO_DIR, wd);
      bus_read(REG_GPIO_DIR, rd);
      check_word("REG_GPIO_DIR", rd, wd & 32'h0000_FFFF);
      wd = word_t'($urandom);
      bus_write(REG_GPIO_OUT, wd);
      bus_read(REG_GPIO_OUT, rd);
      check_word("REG_GPIO_OUT", rd, wd & 32'h0000_FFFF);
      wd = word_t'($urandom);
      bus_write(REG_PWM_ENB, wd);
      bus_read(REG_PWM_ENB, rd);
      check_word("REG_PWM_ENB", rd, wd & 32'h0000_003F);
      n_req += 6;
    end
    // Channel config is a full word
    for (int k = 0; k < NUM_PWM; k++) begin
      addr = REG_PWM_BASE + ADDR_W'(4 * k);
      wd   = word_t'($urandom);
      bus_write(addr, wd);
      bus_read(addr, rd);
      check_word($sformatf("REG_PWM_CH%0d", k), rd, wd);
      n_req += 2;
    end
    // Low two bytes only
    keep = word_t'($urandom);
    wd   = word_t'($urandom);
    bus_write(REG_PWM_BASE, keep);
    bus_write(REG_PWM_BASE, wd, 4'h3);
    bus_read(REG_PWM_BASE, rd);
    check_word("REG_PWM_CH0 partial", rd, {keep[31:16], wd[15:0]});
    // Hole above the last channel
    bus_write(8'h44, word_t'($urandom));
    bus_read(8'h44, rd);
    check_word("unmapped 0x44", rd, '0);
    n_req += 5;
    check_cycles("bus acks", ack_cnt - acks0, n_req);
    check_cycles("ack pulses", ack_seen - seen0, n_req);
    // Back to idle pads
    bus_write(REG_PWM_ENB, '0);
    bus_write(REG_GPIO_DIR, '0);
    finish_test("reg_access", start);
  endtask

  task automatic test_gpio();
    int       start;
    pad_vec_t dir;
    pad_vec_t out;
    word_t    rd;
    start = err_cnt;
    for (int i = 0; i < 6; i++) begin
      dir = pad_vec_t'($urandom);
      out = pad_vec_t'($urandom);
      bus_write(REG_GPIO_DIR, word_t'(dir));
      bus_write(REG_GPIO_OUT, word_t'(out));
      // Undriven pads float with out low
      check_pads("io_out_o", io_out, out & dir);
      check_pads("io_oen_o", io_oen, ~dir);
      io_in = pad_vec_t'($urandom);
      wait_cycles(2);
      bus_read(REG_GPIO_IN, rd);
      check_word("REG_GPIO_IN", rd, word_t'(io_in));
    end
    bus_write(REG_GPIO_DIR, '0);
    finish_test("gpio", start);
  endtask

  task automatic test_timebase();
    int    start;
    int    cyc;
    word_t rd;
    start = err_cnt;
    bus_write(REG_PULSE_US, word_t'(DIV_TEST));
    bus_read(REG_PULSE_US, rd);
    check_word("REG_PULSE_US", rd, word_t'(DIV_TEST));
    // First tick only aligns
    wait_ms_tick(RUN_LIMIT, cyc);
    if (cyc < 0) begin
      $display("No millisecond tick within %0d cycles", RUN_LIMIT);
      err_cnt++;
    end else begin
      for (int i = 0; i < 3; i++) begin
        wait_ms_tick(RUN_LIMIT, cyc);
        if (cyc < 0) begin
          $display("Millisecond tick stopped after %0d good intervals", i);
          err_cnt++;
          break;
        end
        check_cycles("pulse_1ms_o spacing", cyc, MS_PERIOD);
      end
    end
    finish_test("timebase", start);
  endtask

  task automatic test_pwm();
    int       start;
    int       len;
    pad_vec_t oen_exp;
    start  = err_cnt;
    pwm_ch = $urandom % NUM_PWM;
    bus_write(REG_GPIO_DIR, '0);
    // High for 2 ticks and low for 3 ticks
    bus_write(REG_PWM_BASE + ADDR_W'(4 * pwm_ch), {16'd3, 16'd2});
    bus_write(REG_PWM_ENB, word_t'(1) << pwm_ch);
    oen_exp = ~(pad_vec_t'(1) << pwm_ch);
    check_pads("io_oen_o", io_oen, oen_exp);
    // Skip the low lead-in up to the first rising edge
    measure_run(pwm_ch, 1'b0, RUN_LIMIT, len);
    if (io_out[pwm_ch] !== 1'b1) begin
      $display("Pad %0d never went high after enable", pwm_ch);
      err_cnt++;
    end else begin
      for (int r = 0; r < 2; r++) begin
        timed_run(pwm_ch, 1'b1, 2 * MS_PERIOD, "high run");
        check_pads("io_oen_o", io_oen, oen_exp);
        timed_run(pwm_ch, 1'b0, 3 * MS_PERIOD, "low run");
      end
    end
    finish_test("pwm", start);
  endtask

  task automatic test_release();
    int       start;
    pad_vec_t dir;
    pad_vec_t out;
    start = err_cnt;
    dir   = pad_vec_t'($urandom) | (pad_vec_t'(1) << pwm_ch);
    out   = pad_vec_t'($urandom);
    bus_write(REG_GPIO_OUT, word_t'(out));
    bus_write(REG_GPIO_DIR, word_t'(dir));
    // Disable lands on the ack edge and en drops one cycle later
    bus_write(REG_PWM_ENB, '0);
    check_pads("io_out_o", io_out, out & dir);
    check_pads("io_oen_o", io_oen, ~dir);
    // With direction clear the pad floats
    dir[pwm_ch] = 1'b0;
    bus_write(REG_GPIO_DIR, word_t'(dir));
    check_pads("io_out_o", io_out, out & dir);
    check_pads("io_oen_o", io_oen, ~dir);
    finish_test("release", start);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    void'($urandom(SEED));
    rst   = 1'b1;
    req   = '0;
    io_in = '0;
    repeat (4) @(posedge mclk);
    #1;
    rst = 1'b0;
    test_reset_defaults();
    test_reg_access();
    test_gpio();
    test_timebase();
    test_pwm();
    test_release();
    $display("Tests %0d, failed %0d, errors %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

/* verilog.f */
+incdir+include
src/pinmux_pkg.sv
src/pinmux_regs.sv
src/pinmux_timebase.sv
src/pwm_channel.sv
src/pad_mux.sv
src/pinmux_top.sv
verif/tb_pinmux.sv

/* Bender.yml */
package:
  name: pinmux

sources:
  - src/pinmux_pkg.sv
  - src/pinmux_regs.sv
  - src/pinmux_timebase.sv
  - src/pwm_channel.sv
  - src/pad_mux.sv
  - src/pinmux_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_pinmux.sv
